/* chip8_pkg.sv */
/*
 * CHIP-8 core shared types
 * Address, data and opcode types plus the sequencer and datapath control encodings
 */
`default_nettype none

package chip8_pkg;

	// Basic datapath widths
	typedef logic [11:0] addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [15:0] instr_t;

	// VF holds carry, no-borrow and shift-out
	localparam reg_idx_t FLAG_REG = 4'hF;
	// Every instruction is two bytes
	localparam int unsigned INSTR_BYTES = 2;

	// Major opcode, top nibble of the instruction word
	typedef enum logic [3:0] {
		OP_SYS     = 4'h0,
		OP_JP      = 4'h1,
		OP_CALL    = 4'h2,
		OP_SE_IMM  = 4'h3,
		OP_SNE_IMM = 4'h4,
		OP_SE_REG  = 4'h5,
		OP_LD_IMM  = 4'h6,
		OP_ADD_IMM = 4'h7,
		OP_ALU     = 4'h8,
		OP_SNE_REG = 4'h9,
		OP_LD_I    = 4'hA,
		OP_JP_V0   = 4'hB,
		OP_RND     = 4'hC,
		OP_DRW     = 4'hD,
		OP_KEY     = 4'hE,
		OP_MISC    = 4'hF
	} opcode_e;

	// Low nibble of the 8xy group
	typedef enum logic [3:0] {
		SUB_LD   = 4'h0,
		SUB_OR   = 4'h1,
		SUB_AND  = 4'h2,
		SUB_XOR  = 4'h3,
		SUB_ADD  = 4'h4,
		SUB_SUB  = 4'h5,
		SUB_SHR  = 4'h6,
		SUB_SUBN = 4'h7,
		SUB_SHL  = 4'hE
	} alu_sub_e;

	// ALU operation, NOP passes b through
	typedef enum logic [2:0] {
		ALU_NOP,
		ALU_ADD,
		ALU_SUB,
		ALU_OR,
		ALU_AND,
		ALU_XOR,
		ALU_SHR,
		ALU_SHL
	} alu_op_e;

	typedef enum logic [2:0] {
		PC_HOLD,
		PC_NEXT,
		PC_SKIP,
		PC_JUMP,
		PC_RET
	} pc_src_e;

	typedef enum logic [1:0] {
		STK_HOLD,
		STK_PUSH,
		STK_POP
	} stack_op_e;

	typedef enum logic [1:0] {
		SEQ_FETCH,
		SEQ_WAIT_INSTR,
		SEQ_READ,
		SEQ_EXEC
	} seq_state_e;

endpackage

`default_nettype wire

/* chip8_reg_if.sv */
/*
 * V register access bundle
 * Two read ports, one Vx write port and a dedicated VF write port
 */
`timescale 1ns/1ps
`default_nettype none

interface chip8_reg_if;

	// Read side
	chip8_pkg::reg_idx_t rd_addr1;
	chip8_pkg::reg_idx_t rd_addr2;
	chip8_pkg::byte_t    rdata1;
	chip8_pkg::byte_t    rdata2;

	// Write side
	logic                we1;
	chip8_pkg::reg_idx_t waddr1;
	chip8_pkg::byte_t    wdata1;
	logic                flag_we;
	chip8_pkg::byte_t    flag_data;

	modport ctrl (
		output rd_addr1, rd_addr2, we1, waddr1, wdata1, flag_we, flag_data,
		input  rdata1, rdata2
	);

	modport rf (
		input  rd_addr1, rd_addr2, we1, waddr1, wdata1, flag_we, flag_data,
		output rdata1, rdata2
	);

endinterface

`default_nettype wire

/* chip8_alu.sv */
/*
 * CHIP-8 ALU
 * Byte operations with VF flag, plus a separate 12-bit address adder
 */
`timescale 1ns/1ps
`default_nettype none

module chip8_alu (
	input  chip8_pkg::alu_op_e op,
	input  chip8_pkg::byte_t   a,
	input  chip8_pkg::byte_t   b,
	input  chip8_pkg::addr_t   addr_a,
	output chip8_pkg::byte_t   y,
	output chip8_pkg::addr_t   addr_y,
	output logic               flag
);

	// Ninth bit is the carry out
	logic [8:0] sum;

	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		y    = b;
		flag = 1'b0;
		case (op)
			chip8_pkg::ALU_ADD: begin
				y    = sum[7:0];
				flag = sum[8];
			end
			chip8_pkg::ALU_SUB: begin
				y    = a - b;
				// Set when no borrow occurs
				flag = (a >= b);
			end
			chip8_pkg::ALU_OR:  y = a | b;
			chip8_pkg::ALU_AND: y = a & b;
			chip8_pkg::ALU_XOR: y = a ^ b;
			chip8_pkg::ALU_SHR: begin
				y    = {1'b0, a[7:1]};
				flag = a[0];
			end
			chip8_pkg::ALU_SHL: begin
				y    = {a[6:0], 1'b0};
				flag = a[7];
			end
			default: y = b;
		endcase
	end

	// nnn + V0 for Bnnn, I + Vx for Fx1E, wraps at 12 bits
	assign addr_y = addr_a + chip8_pkg::addr_t'(b);

endmodule

`default_nettype wire

/* chip8_reg_file.sv */
/*
 * V0..VF register file
 * Combinational reads, clocked writes, VF port overrides a Vx write to VF
 */
`timescale 1ns/1ps
`default_nettype none

module chip8_reg_file (
	input logic       cpu_clk,
	input logic       rst_n,
	chip8_reg_if.rf   regs
);

	chip8_pkg::byte_t v_regs [16];

	// Asynchronous read ports
	assign regs.rdata1 = v_regs[regs.rd_addr1];
	assign regs.rdata2 = v_regs[regs.rd_addr2];

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++) begin
				v_regs[i] <= '0;
			end
		end else begin
			if (regs.we1) begin
				v_regs[regs.waddr1] <= regs.wdata1;
			end
			// Later assignment wins when x is 15
			if (regs.flag_we) begin
				v_regs[chip8_pkg::FLAG_REG] <= regs.flag_data;
			end
		end
	end

endmodule

`default_nettype wire

/* chip8_pc_stack.sv */
/*
 * Program counter and subroutine stack
 * Applies next, skip, jump and return, pushes PC + 2 on a call
 */
`timescale 1ns/1ps
`default_nettype none

module chip8_pc_stack #(
	parameter chip8_pkg::addr_t PROG_START  = 12'h200,
	parameter int unsigned      STACK_DEPTH = 16
) (
	input  logic                 cpu_clk,
	input  logic                 rst_n,
	input  chip8_pkg::pc_src_e   pc_src,
	input  chip8_pkg::addr_t     jump_target,
	input  chip8_pkg::stack_op_e stk_op,
	output chip8_pkg::addr_t     pc
);

	localparam int unsigned SP_W = (STACK_DEPTH > 1) ? $clog2(STACK_DEPTH) : 1;
	localparam logic [SP_W-1:0] SP_LAST = SP_W'(STACK_DEPTH - 1);

	chip8_pkg::addr_t stack_mem [STACK_DEPTH];
	logic [SP_W-1:0]  sp;
	logic [SP_W-1:0]  sp_inc;
	logic [SP_W-1:0]  sp_dec;
	chip8_pkg::addr_t pc_plus2;
	chip8_pkg::addr_t pc_plus4;

	// Pointer wraps modulo STACK_DEPTH, even when not a power of two
	assign sp_inc = (sp == SP_LAST) ? '0 : sp + 1'b1;
	assign sp_dec = (sp == '0) ? SP_LAST : sp - 1'b1;

	assign pc_plus2 = pc + chip8_pkg::addr_t'(chip8_pkg::INSTR_BYTES);
	assign pc_plus4 = pc + chip8_pkg::addr_t'(2 * chip8_pkg::INSTR_BYTES);

	// PC and pointer, updated at the end of exec
	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			pc <= PROG_START;
			sp <= '0;
		end else begin
			case (pc_src)
				chip8_pkg::PC_NEXT: pc <= pc_plus2;
				chip8_pkg::PC_SKIP: pc <= pc_plus4;
				chip8_pkg::PC_JUMP: pc <= jump_target;
				chip8_pkg::PC_RET:  pc <= stack_mem[sp_dec];
				default:            pc <= pc;
			endcase
			case (stk_op)
				chip8_pkg::STK_PUSH: sp <= sp_inc;
				chip8_pkg::STK_POP:  sp <= sp_dec;
				default:             sp <= sp;
			endcase
		end
	end

	// Return address storage
	always_ff @(posedge cpu_clk) begin
		if (stk_op == chip8_pkg::STK_PUSH) begin
			stack_mem[sp] <= pc_plus2;
		end
	end

endmodule

`default_nettype wire

/* chip8_exec_ctrl.sv */
/*
 * CHIP-8 fetch sequencer and decoder
 * Latches each word, reads operands, then drives register, I and PC updates
 */
`timescale 1ns/1ps
`default_nettype none

module chip8_exec_ctrl (
	input  logic                 cpu_clk,
	input  logic                 rst_n,
	input  logic                 instr_valid,
	input  chip8_pkg::instr_t    instr,
	input  chip8_pkg::addr_t     pc,
	input  chip8_pkg::byte_t     alu_y,
	input  chip8_pkg::addr_t     alu_addr_y,
	input  logic                 alu_flag,
	chip8_reg_if.ctrl            regs,
	output logic                 fetch_req,
	output chip8_pkg::alu_op_e   alu_op,
	output chip8_pkg::byte_t     alu_a,
	output chip8_pkg::byte_t     alu_b,
	output chip8_pkg::addr_t     alu_addr_a,
	output chip8_pkg::pc_src_e   pc_src,
	output chip8_pkg::addr_t     jump_target,
	output chip8_pkg::stack_op_e stk_op,
	output chip8_pkg::addr_t     i_reg
);

	chip8_pkg::seq_state_e state;
	chip8_pkg::seq_state_e state_next;
	chip8_pkg::instr_t     instr_q;
	chip8_pkg::addr_t      i_next;

	// Opcode fields of the latched word
	chip8_pkg::opcode_e  opcode;
	chip8_pkg::alu_sub_e sub_op;
	chip8_pkg::reg_idx_t x_idx;
	chip8_pkg::reg_idx_t y_idx;
	chip8_pkg::byte_t    kk;
	chip8_pkg::addr_t    nnn;
	logic [3:0]          n_low;

	assign opcode = chip8_pkg::opcode_e'(instr_q[15:12]);
	assign sub_op = chip8_pkg::alu_sub_e'(instr_q[3:0]);
	assign x_idx  = instr_q[11:8];
	assign y_idx  = instr_q[7:4];
	assign kk     = instr_q[7:0];
	assign nnn    = instr_q[11:0];
	assign n_low  = instr_q[3:0];

	// Write port fields come straight from the latched word and the ALU
	assign regs.waddr1    = x_idx;
	assign regs.wdata1    = alu_y;
	assign regs.flag_data = {7'b0, alu_flag};

	// Sequencer next state
	always_comb begin
		state_next = state;
		case (state)
			// Leave fetch once the request has been shown for a cycle
			chip8_pkg::SEQ_FETCH: if (fetch_req) state_next = chip8_pkg::SEQ_WAIT_INSTR;
			chip8_pkg::SEQ_WAIT_INSTR: if (instr_valid) state_next = chip8_pkg::SEQ_READ;
			chip8_pkg::SEQ_READ: state_next = chip8_pkg::SEQ_EXEC;
			default: state_next = chip8_pkg::SEQ_FETCH;
		endcase
	end

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			state     <= chip8_pkg::SEQ_FETCH;
			fetch_req <= 1'b0;
			i_reg     <= '0;
		end else begin
			state     <= state_next;
			// Request is high for exactly the one cycle spent in fetch
			fetch_req <= (state_next == chip8_pkg::SEQ_FETCH) && !fetch_req;
			i_reg     <= i_next;
		end
	end

	// Word arrives only while waiting
	always_ff @(posedge cpu_clk) begin
		if (state == chip8_pkg::SEQ_WAIT_INSTR && instr_valid) begin
			instr_q <= instr;
		end
	end

	// Decode and execute
	always_comb begin
		alu_op        = chip8_pkg::ALU_NOP;
		alu_a         = '0;
		alu_b         = '0;
		alu_addr_a    = '0;
		pc_src        = chip8_pkg::PC_HOLD;
		jump_target   = '0;
		stk_op        = chip8_pkg::STK_HOLD;
		regs.rd_addr1 = '0;
		regs.rd_addr2 = '0;
		regs.we1      = 1'b0;
		regs.flag_we  = 1'b0;
		i_next        = i_reg;

		// Operand addresses stay up through exec for the combinational reads
		if (state == chip8_pkg::SEQ_READ || state == chip8_pkg::SEQ_EXEC) begin
			// Bnnn reads V0 on port 1
			regs.rd_addr1 = (opcode == chip8_pkg::OP_JP_V0) ? 4'h0 : x_idx;
			regs.rd_addr2 = y_idx;
		end

		if (state == chip8_pkg::SEQ_EXEC) begin
			// Anything undecoded just steps past
			pc_src = chip8_pkg::PC_NEXT;
			case (opcode)
				chip8_pkg::OP_SYS: begin
					if (instr_q == 16'h00EE) begin
						pc_src = chip8_pkg::PC_RET;
						stk_op = chip8_pkg::STK_POP;
					end
				end
				chip8_pkg::OP_JP: begin
					pc_src      = chip8_pkg::PC_JUMP;
					jump_target = nnn;
				end
				chip8_pkg::OP_CALL: begin
					// Stack saves PC + 2 itself
					pc_src      = chip8_pkg::PC_JUMP;
					jump_target = nnn;
					stk_op      = chip8_pkg::STK_PUSH;
				end
				chip8_pkg::OP_SE_IMM: begin
					if (regs.rdata1 == kk) pc_src = chip8_pkg::PC_SKIP;
				end
				chip8_pkg::OP_SNE_IMM: begin
					if (regs.rdata1 != kk) pc_src = chip8_pkg::PC_SKIP;
				end
				chip8_pkg::OP_SE_REG: begin
					if (n_low == 4'h0 && regs.rdata1 == regs.rdata2) begin
						pc_src = chip8_pkg::PC_SKIP;
					end
				end
				chip8_pkg::OP_SNE_REG: begin
					if (n_low == 4'h0 && regs.rdata1 != regs.rdata2) begin
						pc_src = chip8_pkg::PC_SKIP;
					end
				end
				chip8_pkg::OP_LD_IMM: begin
					// NOP passes kk straight through
					alu_b    = kk;
					regs.we1 = 1'b1;
				end
				chip8_pkg::OP_ADD_IMM: begin
					// No carry into VF for 7xkk
					alu_op   = chip8_pkg::ALU_ADD;
					alu_a    = regs.rdata1;
					alu_b    = kk;
					regs.we1 = 1'b1;
				end
				chip8_pkg::OP_ALU: begin
					alu_a = regs.rdata1;
					alu_b = regs.rdata2;
					case (sub_op)
						chip8_pkg::SUB_LD: regs.we1 = 1'b1;
						chip8_pkg::SUB_OR: begin
							alu_op   = chip8_pkg::ALU_OR;
							regs.we1 = 1'b1;
						end
						chip8_pkg::SUB_AND: begin
							alu_op   = chip8_pkg::ALU_AND;
							regs.we1 = 1'b1;
						end
						chip8_pkg::SUB_XOR: begin
							alu_op   = chip8_pkg::ALU_XOR;
							regs.we1 = 1'b1;
						end
						chip8_pkg::SUB_ADD: begin
							alu_op       = chip8_pkg::ALU_ADD;
							regs.we1     = 1'b1;
							regs.flag_we = 1'b1;
						end
						chip8_pkg::SUB_SUB: begin
							alu_op       = chip8_pkg::ALU_SUB;
							regs.we1     = 1'b1;
							regs.flag_we = 1'b1;
						end
						chip8_pkg::SUB_SHR: begin
							alu_op       = chip8_pkg::ALU_SHR;
							regs.we1     = 1'b1;
							regs.flag_we = 1'b1;
						end
						chip8_pkg::SUB_SUBN: begin
							// Vy - Vx with the operands swapped
							alu_op       = chip8_pkg::ALU_SUB;
							alu_a        = regs.rdata2;
							alu_b        = regs.rdata1;
							regs.we1     = 1'b1;
							regs.flag_we = 1'b1;
						end
						chip8_pkg::SUB_SHL: begin
							alu_op       = chip8_pkg::ALU_SHL;
							regs.we1     = 1'b1;
							regs.flag_we = 1'b1;
						end
						default: regs.we1 = 1'b0;
					endcase
				end
				chip8_pkg::OP_LD_I: i_next = nnn;
				chip8_pkg::OP_JP_V0: begin
					// nnn + V0 through the address adder
					alu_addr_a  = nnn;
					alu_b       = regs.rdata1;
					pc_src      = chip8_pkg::PC_JUMP;
					jump_target = alu_addr_y;
				end
				chip8_pkg::OP_MISC: begin
					if (kk == 8'h1E) begin
						alu_addr_a = i_reg;
						alu_b      = regs.rdata1;
						i_next     = alu_addr_y;
					end
				end
				default: pc_src = chip8_pkg::PC_NEXT;
			endcase
		end
	end

endmodule

`default_nettype wire

/* chip8_cpu.sv */
/*
 * CHIP-8 instruction core top level
 * Connects sequencer, register file, PC/stack and ALU to the fetch and trace ports
 */
`timescale 1ns/1ps
`default_nettype none

module chip8_cpu #(
	parameter chip8_pkg::addr_t PROG_START  = 12'h200,
	parameter int unsigned      STACK_DEPTH = 16
) (
	input  logic                cpu_clk,
	input  logic                rst_n,
	input  logic                instr_valid,
	input  chip8_pkg::instr_t   instr,
	output logic                fetch_req,
	output chip8_pkg::addr_t    fetch_addr,
	output logic                v_we,
	output chip8_pkg::reg_idx_t v_addr,
	output chip8_pkg::byte_t    v_data,
	output logic                flag_we,
	output chip8_pkg::byte_t    flag_data,
	output chip8_pkg::addr_t    i_reg
);

	chip8_pkg::addr_t     pc;
	chip8_pkg::alu_op_e   alu_op;
	chip8_pkg::byte_t     alu_a;
	chip8_pkg::byte_t     alu_b;
	chip8_pkg::addr_t     alu_addr_a;
	chip8_pkg::byte_t     alu_y;
	chip8_pkg::addr_t     alu_addr_y;
	logic                 alu_flag;
	chip8_pkg::pc_src_e   pc_src;
	chip8_pkg::addr_t     jump_target;
	chip8_pkg::stack_op_e stk_op;

	chip8_reg_if regs ();

	chip8_exec_ctrl u_ctrl (
		.cpu_clk     (cpu_clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.alu_y       (alu_y),
		.alu_addr_y  (alu_addr_y),
		.alu_flag    (alu_flag),
		.regs        (regs.ctrl),
		.fetch_req   (fetch_req),
		.alu_op      (alu_op),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_addr_a  (alu_addr_a),
		.pc_src      (pc_src),
		.jump_target (jump_target),
		.stk_op      (stk_op),
		.i_reg       (i_reg)
	);

	chip8_reg_file u_regs (
		.cpu_clk (cpu_clk),
		.rst_n   (rst_n),
		.regs    (regs.rf)
	);

	chip8_pc_stack #(
		.PROG_START  (PROG_START),
		.STACK_DEPTH (STACK_DEPTH)
	) u_pc_stack (
		.cpu_clk     (cpu_clk),
		.rst_n       (rst_n),
		.pc_src      (pc_src),
		.jump_target (jump_target),
		.stk_op      (stk_op),
		.pc          (pc)
	);

	chip8_alu u_alu (
		.op     (alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.addr_a (alu_addr_a),
		.y      (alu_y),
		.addr_y (alu_addr_y),
		.flag   (alu_flag)
	);

	// Fetch always targets the current PC
	assign fetch_addr = pc;

	// Writeback trace mirrors the register file write port
	assign v_we      = regs.we1;
	assign v_addr    = regs.waddr1;
	assign v_data    = regs.wdata1;
	assign flag_we   = regs.flag_we;
	assign flag_data = regs.flag_data;

endmodule

`default_nettype wire

/* tb_chip8_cpu.sv */
/*
 * Testbench for the CHIP-8 instruction core
 * Program memory with random fetch latency, reference model and per-instruction checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_chip8_cpu;

	localparam logic [11:0] PROG_START    = 12'h200;
	localparam int          STACK_DEPTH   = 16;
	localparam int          FETCH_TIMEOUT = 32;

	// DUT connections
	logic        clk = 1'b0;
	logic        rst_n;
	logic        instr_valid;
	logic [15:0] instr;
	logic        fetch_req;
	logic [11:0] fetch_addr;
	logic        v_we;
	logic [3:0]  v_addr;
	logic [7:0]  v_data;
	logic        flag_we;
	logic [7:0]  flag_data;
	logic [11:0] i_reg;

	// Program memory with one byte per address
	logic [7:0] prog_mem [4096];

	// Reference model state
	logic [7:0]  v_m [16];
	logic [11:0] stk_m [16];
	logic [3:0]  sp_m;
	logic [11:0] pc_m;
	logic [11:0] i_m;

	// Expected writeback of the instruction in flight
	logic        exp_we;
	logic [3:0]  exp_addr;
	logic [7:0]  exp_data;
	logic        exp_fwe;
	logic [7:0]  exp_fdata;

	// Bookkeeping
	integer seed;
	string  test_name;
	int     errors;
	int     err_mark;
	int     checks;
	int     tests_run;
	int     tests_failed;
	logic   hung;

	chip8_cpu #(
		.PROG_START  (PROG_START),
		.STACK_DEPTH (STACK_DEPTH)
	) DUT (
		.cpu_clk     (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.fetch_req   (fetch_req),
		.fetch_addr  (fetch_addr),
		.v_we        (v_we),
		.v_addr      (v_addr),
		.v_data      (v_data),
		.flag_we     (flag_we),
		.flag_data   (flag_data),
		.i_reg       (i_reg)
	);

	always #4 clk = ~clk;

	// Request and trace strobes are single-cycle pulses
	assert property (@(posedge clk) disable iff (!rst_n) fetch_req |=> !fetch_req)
		else begin
			errors++;
			$display("Error: fetch_req stayed high for two cycles in %s", test_name);
		end
	assert property (@(posedge clk) disable iff (!rst_n) (v_we || flag_we) |=> !(v_we || flag_we))
		else begin
			errors++;
			$display("Error: register write strobe stayed high for two cycles in %s", test_name);
		end

	function automatic logic [7:0] rand_byte();
		rand_byte = 8'($random(seed));
	endfunction

	function automatic logic [3:0] rand_nib();
		rand_nib = 4'($random(seed));
	endfunction

	function automatic logic [11:0] rand_addr();
		rand_addr = 12'($random(seed));
	endfunction

	task automatic check_value(input string what, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (act === exp)
			else begin
				errors++;
				$display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
			end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_mark  = errors;
		tests_run++;
	endtask

	task automatic finish_test();
		if (hung) begin
			tests_failed++;
			$display("%-14s stopped by a timeout", test_name);
		end else if (errors == err_mark) begin
			$display("%-14s ok", test_name);
		end else begin
			tests_failed++;
			$display("%-14s %0d errors", test_name, errors - err_mark);
		end
	endtask

	// CHIP-8 semantics for the 8xy group
	task automatic model_alu(input logic [3:0] sub, input logic [7:0] vx, input logic [7:0] vy);
		logic [8:0] wide;
		wide = {1'b0, vx} + {1'b0, vy};
		exp_we = 1'b1;
		case (sub)
			4'h0: exp_data = vy;
			4'h1: exp_data = vx | vy;
			4'h2: exp_data = vx & vy;
			4'h3: exp_data = vx ^ vy;
			4'h4: begin
				exp_data  = wide[7:0];
				exp_fwe   = 1'b1;
				exp_fdata = {7'b0, wide[8]};
			end
			4'h5: begin
				exp_data  = vx - vy;
				exp_fwe   = 1'b1;
				exp_fdata = {7'b0, vx >= vy};
			end
			4'h6: begin
				exp_data  = vx >> 1;
				exp_fwe   = 1'b1;
				exp_fdata = {7'b0, vx[0]};
			end
			4'h7: begin
				exp_data  = vy - vx;
				exp_fwe   = 1'b1;
				exp_fdata = {7'b0, vy >= vx};
			end
			4'hE: begin
				exp_data  = vx << 1;
				exp_fwe   = 1'b1;
				exp_fdata = {7'b0, vx[7]};
			end
			// Undefined subcodes write nothing
			default: exp_we = 1'b0;
		endcase
	endtask

	// Reference model that sets the expected trace and advances the state
	task automatic model_exec(input logic [15:0] w);
		logic [3:0]  x;
		logic [3:0]  y;
		logic [7:0]  kk;
		logic [11:0] nnn;
		logic [7:0]  vx;
		logic [7:0]  vy;
		logic [11:0] pc_nx;
		x        = w[11:8];
		y        = w[7:4];
		kk       = w[7:0];
		nnn      = w[11:0];
		vx       = v_m[x];
		vy       = v_m[y];
		pc_nx    = pc_m + 12'd2;
		exp_we   = 1'b0;
		exp_addr = x;
		exp_data = 8'h00;
		exp_fwe  = 1'b0;
		exp_fdata = 8'h00;
		case (w[15:12])
			4'h0: begin
				if (w == 16'h00EE) begin
					sp_m  = sp_m - 4'd1;
					pc_nx = stk_m[sp_m];
				end
			end
			4'h1: pc_nx = nnn;
			4'h2: begin
				stk_m[sp_m] = pc_m + 12'd2;
				sp_m        = sp_m + 4'd1;
				pc_nx       = nnn;
			end
			4'h3: if (vx == kk) pc_nx = pc_m + 12'd4;
			4'h4: if (vx != kk) pc_nx = pc_m + 12'd4;
			4'h5: if (w[3:0] == 4'h0 && vx == vy) pc_nx = pc_m + 12'd4;
			4'h6: begin
				exp_we   = 1'b1;
				exp_data = kk;
			end
			4'h7: begin
				exp_we   = 1'b1;
				exp_data = vx + kk;
			end
			4'h8: model_alu(w[3:0], vx, vy);
			4'h9: if (w[3:0] == 4'h0 && vx != vy) pc_nx = pc_m + 12'd4;
			4'hA: i_m = nnn;
			4'hB: pc_nx = nnn + {4'h0, v_m[0]};
			4'hF: if (kk == 8'h1E) i_m = i_m + {4'h0, vx};
			default: pc_nx = pc_m + 12'd2;
		endcase
		// VF write lands after the Vx write
		if (exp_we) v_m[x] = exp_data;
		if (exp_fwe) v_m[15] = exp_fdata;
		pc_m = pc_nx;
	endtask

	// Serve one fetch with a word and check the whole instruction cycle
	task automatic exec_word(input logic [15:0] word);
		int          cnt;
		int          dly;
		logic [11:0] addr;
		if (hung) return;
		addr                   = pc_m;
		prog_mem[addr]         = word[15:8];
		prog_mem[addr + 12'd1] = word[7:0];
		cnt = 0;
		while (!fetch_req && cnt < FETCH_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!fetch_req) begin
			$display("Timeout: no fetch request for PC %h in %s", addr, test_name);
			hung = 1'b1;
			return;
		end
		check_value("fetch_addr", 16'(addr), 16'(fetch_addr));
		// Memory latency of 1 to 4 cycles
		dly = 1 + int'($unsigned($random(seed)) % 32'd4);
		repeat (dly) @(negedge clk);
		instr_valid = 1'b1;
		instr       = {prog_mem[addr], prog_mem[addr + 12'd1]};
		model_exec(word);
		@(negedge clk);
		// Read cycle where a changed bus must not matter
		instr_valid = 1'b0;
		instr       = ~word;
		check_value("fetch_req in read", 16'h0, 16'(fetch_req));
		check_value("v_we in read", 16'h0, 16'(v_we));
		@(negedge clk);
		// Exec cycle carries the writeback trace
		check_value("fetch_req in exec", 16'h0, 16'(fetch_req));
		check_value("v_we", 16'(exp_we), 16'(v_we));
		check_value("flag_we", 16'(exp_fwe), 16'(flag_we));
		if (exp_we) begin
			check_value("v_addr", 16'(exp_addr), 16'(v_addr));
			check_value("v_data", 16'(exp_data), 16'(v_data));
		end
		if (exp_fwe) check_value("flag_data", 16'(exp_fdata), 16'(flag_data));
		@(negedge clk);
		// Next request exactly 3 cycles after instr_valid
		check_value("fetch_req after exec", 16'h1, 16'(fetch_req));
		check_value("next fetch_addr", 16'(pc_m), 16'(fetch_addr));
		check_value("i_reg", 16'(i_m), 16'(i_reg));
	endtask

	task automatic test_fetch_timing();
		start_test("fetch_timing");
		repeat (3) begin
			@(negedge clk);
			check_value("fetch_req in reset", 16'h0, 16'(fetch_req));
			check_value("v_we in reset", 16'h0, 16'(v_we));
			check_value("flag_we in reset", 16'h0, 16'(flag_we));
		end
		rst_n = 1'b1;
		@(negedge clk);
		check_value("first fetch_req", 16'h1, 16'(fetch_req));
		check_value("first fetch_addr", 16'(PROG_START), 16'(fetch_addr));
		// Undecoded words only step the PC
		exec_word(16'h0123);
		exec_word(16'h8008);
		exec_word(16'hE19E);
		exec_word(16'hF0FF);
		exec_word(16'hD123);
		finish_test();
	endtask

	task automatic test_immediates();
		logic [3:0] x;
		start_test("immediates");
		repeat (16) begin
			x = rand_nib();
			exec_word({4'h6, x, rand_byte()});
			exec_word({4'h7, x, rand_byte()});
		end
		finish_test();
	endtask

	task automatic test_alu_ops();
		logic [3:0] subs [9];
		logic [3:0] x;
		logic [3:0] y;
		subs = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'hE};
		start_test("alu_ops");
		for (int s = 0; s < 9; s++) begin
			for (int r = 0; r < 6; r++) begin
				x = rand_nib();
				y = rand_nib();
				// Last pass targets VF itself
				if (r == 5) x = 4'hF;
				exec_word({4'h6, x, rand_byte()});
				exec_word({4'h6, y, rand_byte()});
				exec_word({4'h8, x, y, subs[s]});
				// Copy VF into V0 so the stored flag shows up on the trace
				exec_word(16'h80F0);
			end
		end
		finish_test();
	endtask

	task automatic test_skips();
		logic [3:0] x;
		logic [3:0] y;
		logic [7:0] val;
		start_test("skips");
		for (int op = 3; op <= 4; op++) begin
			for (int eq = 0; eq < 2; eq++) begin
				x   = rand_nib();
				val = rand_byte();
				exec_word({4'h6, x, val});
				exec_word({4'(op), x, (eq != 0) ? val : (val ^ 8'h5A)});
				exec_word(16'h0000);
			end
		end
		for (int k = 0; k < 5; k++) begin
			x   = rand_nib();
			y   = x ^ 4'h3;
			val = rand_byte();
			exec_word({4'h6, x, val});
			exec_word({4'h6, y, (k % 2 == 0) ? val : (val + 8'd1)});
			// Nonzero low nibble on the last round is not a skip
			exec_word({(k < 2) ? 4'h5 : 4'h9, x, y, (k == 4) ? 4'h1 : 4'h0});
			exec_word(16'h0000);
		end
		finish_test();
	endtask

	task automatic test_control_flow();
		start_test("control_flow");
		exec_word(16'h1340);
		exec_word(16'h2600);
		exec_word(16'h6355);
		exec_word(16'h27A0);
		exec_word(16'h7301);
		exec_word(16'h00EE);
		exec_word(16'h00EE);
		// Deeper random call chain
		repeat (5) exec_word({4'h2, rand_addr()});
		repeat (5) exec_word(16'h00EE);
		exec_word({8'h60, rand_byte()});
		// Near the top of memory so the sum wraps
		exec_word(16'hBFF8);
		exec_word({8'h60, rand_byte()});
		exec_word({4'hB, rand_addr()});
		exec_word(16'h1200);
		finish_test();
	endtask

	task automatic test_i_register();
		logic [3:0] x;
		start_test("i_register");
		repeat (5) begin
			exec_word({4'hA, rand_addr()});
			repeat (3) begin
				x = rand_nib();
				exec_word({4'h6, x, rand_byte()});
				exec_word({4'hF, x, 8'h1E});
			end
		end
		exec_word(16'hAFF0);
		exec_word(16'h62FF);
		exec_word(16'hF21E);
		// Block load is not part of this core
		exec_word(16'hF265);
		finish_test();
	endtask

	initial begin
		rst_n        = 1'b0;
		instr_valid  = 1'b0;
		instr        = 16'h0000;
		seed         = 32'h9a79_d7e9;
		errors       = 0;
		err_mark     = 0;
		checks       = 0;
		tests_run    = 0;
		tests_failed = 0;
		hung         = 1'b0;
		test_name    = "reset";
		for (int a = 0; a < 4096; a++) begin
			prog_mem[a] = 8'(a ^ (a >> 5) ^ 32'h3C);
		end
		for (int r = 0; r < 16; r++) begin
			v_m[r]   = 8'h00;
			stk_m[r] = 12'h000;
		end
		sp_m = 4'd0;
		pc_m = PROG_START;
		i_m  = 12'h000;

		test_fetch_timing();
		test_immediates();
		test_alu_ops();
		test_skips();
		test_control_flow();
		test_i_register();

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0 && !hung) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
chip8_pkg.sv
chip8_reg_if.sv
chip8_alu.sv
chip8_reg_file.sv
chip8_pc_stack.sv
chip8_exec_ctrl.sv
chip8_cpu.sv
tb_chip8_cpu.sv

/* run.sh */
#!/bin/sh
# Build and run the CHIP-8 core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_chip8_cpu -f files.f -o sim_chip8
./obj_dir/sim_chip8 > sim.log 2>&1
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
	exit 1
fi
exit 0
